// File: hdl/sk_daq_settings.svh
// Front-end controller settings
`ifndef SK_DAQ_SETTINGS_SVH
`define SK_DAQ_SETTINGS_SVH

// Field widths
`define SK_CMD_W        16
`define SK_ADDR_W       3
`define SK_DATA_W       12
`define SK_ACT_W        3
`define SK_THR_W        10
`define SK_CHIPID_W     8
`define SK_FBCAP_W      4
`define SK_MASK_W       48
`define SK_FRAME_BYTES  9     // 72-bit slow-control frame
`define SK_WORD_W       16    // Readout word
`define SK_FIFO_DEPTH   16

// Register map
`define SK_REG_THR      3'd0
`define SK_REG_CHIPID   3'd1
`define SK_REG_OPT      3'd2
`define SK_REG_MASK0    3'd3
`define SK_REG_MASK1    3'd4
`define SK_REG_MASK2    3'd5
`define SK_REG_MASK3    3'd6

// Control actions
`define SK_ACT_CONFIG     3'd0
`define SK_ACT_ACQ_START  3'd1
`define SK_ACT_ACQ_STOP   3'd2

`endif

// File: hdl/sk_daq_pkg.sv
// Front-end controller types
`include "sk_daq_settings.svh"

package sk_daq_pkg;

	////////////////////////////////////////
	// Host command word
	////////////////////////////////////////

	// Same 16 bits, two views picked by the kind bit
	typedef union packed
	{
		struct packed
		{
			logic                  kind;    // 0 = register write
			logic [`SK_ADDR_W-1:0] addr;
			logic [`SK_DATA_W-1:0] data;
		} wr;
		struct packed
		{
			logic                  kind;    // 1 = control action
			logic [`SK_ACT_W-1:0]  action;
			logic [`SK_DATA_W-1:0] unused;  // Don't care
		} ctl;
	} cmd_word_u;

	////////////////////////////////////////
	// Slow control and acquisition
	////////////////////////////////////////

	// Field order is the frame order, MSB first
	typedef struct packed
	{
		logic [`SK_THR_W-1:0]    thr;            // Threshold DAC
		logic [`SK_CHIPID_W-1:0] chip_id;
		logic [`SK_FBCAP_W-1:0]  fb_cap;         // Feedback cap select
		logic                    disc_en;        // Trigger discriminator enable
		logic                    ext_trig_only;
		logic [`SK_MASK_W-1:0]   mask;           // Bits 47..0
	} sc_settings_t;

	typedef struct packed
	{
		logic [7:0] data;
		logic       last;    // Final byte of the frame
	} sc_byte_t;

	typedef struct packed
	{
		logic start_acq;      // Level
		logic start_readout;  // One-cycle pulse
	} acq_ctrl_t;

endpackage

// File: hdl/cmd_decoder.sv
// Host command decoder
`timescale 1ns/1ns
`include "sk_daq_settings.svh"

module cmd_decoder
(
	input  logic                     Clk_Out_2_All,
	input  logic                     reset_i,
	input  sk_daq_pkg::cmd_word_u    cmd_data_i,
	input  logic                     cmd_valid_i,
	input  logic                     sc_busy_i,     // Frame in progress
	output logic                     cmd_ready_o,
	output sk_daq_pkg::sc_settings_t settings_o,
	output logic                     sc_start_o,
	output logic                     acq_enable_o
);

	logic cmd_fire;   // Word accepted this edge
	logic is_write;

	// Hold off from CONFIG until the shifter is done
	assign cmd_ready_o = ~(sc_busy_i | sc_start_o);
	assign cmd_fire    = cmd_valid_i & cmd_ready_o;
	assign is_write    = ~cmd_data_i.wr.kind;  // Kind bit sits at the same place in both views

	////////////////////////////////////////
	// Register writes and actions
	////////////////////////////////////////

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (reset_i)
		begin
			settings_o   <= '0;
			sc_start_o   <= 1'b0;
			acq_enable_o <= 1'b0;
		end
		else
		begin
			sc_start_o <= 1'b0;  // Pulse only
			if (cmd_fire && is_write)
			begin
				case (cmd_data_i.wr.addr)
					`SK_REG_THR:
						settings_o.thr <= cmd_data_i.wr.data[`SK_THR_W-1:0];
					`SK_REG_CHIPID:
						settings_o.chip_id <= cmd_data_i.wr.data[`SK_CHIPID_W-1:0];
					`SK_REG_OPT:
					begin
						settings_o.fb_cap        <= cmd_data_i.wr.data[`SK_FBCAP_W-1:0];
						settings_o.disc_en       <= cmd_data_i.wr.data[4];
						settings_o.ext_trig_only <= cmd_data_i.wr.data[5];
					end
					// Mask slices, 12 channels each
					`SK_REG_MASK0:
						settings_o.mask[0*`SK_DATA_W +: `SK_DATA_W] <= cmd_data_i.wr.data;
					`SK_REG_MASK1:
						settings_o.mask[1*`SK_DATA_W +: `SK_DATA_W] <= cmd_data_i.wr.data;
					`SK_REG_MASK2:
						settings_o.mask[2*`SK_DATA_W +: `SK_DATA_W] <= cmd_data_i.wr.data;
					`SK_REG_MASK3:
						settings_o.mask[3*`SK_DATA_W +: `SK_DATA_W] <= cmd_data_i.wr.data;
					default:
						;  // Unmapped address
				endcase
			end
			else if (cmd_fire)
			begin
				// Control view of the same word
				case (cmd_data_i.ctl.action)
					`SK_ACT_CONFIG:
						sc_start_o <= 1'b1;
					`SK_ACT_ACQ_START:
						acq_enable_o <= 1'b1;
					`SK_ACT_ACQ_STOP:
						acq_enable_o <= 1'b0;
					default:
						;
				endcase
			end
		end
	end

endmodule

// File: hdl/sc_frame_builder.sv
// Slow-control frame builder
`timescale 1ns/1ns
`include "sk_daq_settings.svh"

module sc_frame_builder
(
	input  logic                     Clk_Out_2_All,
	input  logic                     reset_i,
	input  sk_daq_pkg::sc_settings_t settings_i,
	input  logic                     sc_start_i,
	input  logic                     sc_done_i,     // From shifter
	input  logic                     byte_ready_i,
	output logic                     sc_busy_o,
	output sk_daq_pkg::sc_byte_t     byte_o,
	output logic                     byte_valid_o
);

	localparam int FRAME_W = `SK_FRAME_BYTES * 8;   // 72 bits
	localparam int IDX_W   = $clog2(`SK_FRAME_BYTES);

	logic [FRAME_W-1:0] frame_q;    // Snapshot, top byte goes out next
	logic [IDX_W-1:0]   byte_idx;
	logic               byte_fire;
	logic               last_byte;

	assign byte_fire = byte_valid_o & byte_ready_i;
	assign last_byte = (byte_idx == IDX_W'(`SK_FRAME_BYTES - 1));
	assign byte_o    = {frame_q[FRAME_W-1 -: 8], last_byte};

	// Snapshot at start, then move up one byte per transfer
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (sc_start_i)
			frame_q <= settings_i;
		else if (byte_fire)
			frame_q <= frame_q << 8;
	end

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (reset_i)
		begin
			sc_busy_o    <= 1'b0;
			byte_valid_o <= 1'b0;
			byte_idx     <= '0;
		end
		else if (sc_start_i)
		begin
			sc_busy_o    <= 1'b1;   // Until the shifter reports done
			byte_valid_o <= 1'b1;
			byte_idx     <= '0;
		end
		else
		begin
			if (byte_fire)
			begin
				byte_idx <= byte_idx + 1'b1;
				if (last_byte)
					byte_valid_o <= 1'b0;  // Ninth byte gone
			end
			if (sc_done_i)
				sc_busy_o <= 1'b0;
		end
	end

endmodule

// File: hdl/sc_shifter.sv
// Slow-control serial shifter
`timescale 1ns/1ns

module sc_shifter
(
	input  logic                 Clk_Out_2_All,
	input  logic                 reset_i,
	input  sk_daq_pkg::sc_byte_t byte_i,
	input  logic                 byte_valid_i,
	output logic                 byte_ready_o,
	output logic                 sr_ck_o,       // Chip samples on rising edge
	output logic                 sr_in_o,
	output logic                 sc_done_o
);

	logic [7:0] shreg;      // MSB drives sr_in
	logic       last_q;     // Byte in flight ends the frame
	logic       loaded;
	logic [2:0] bit_idx;    // Bits still to go after this one
	logic       byte_end;
	logic       byte_fire;

	// High phase of bit 0 ends the byte
	assign byte_end     = loaded & sr_ck_o & (bit_idx == 3'd0);
	assign byte_ready_o = ~loaded | byte_end;
	assign byte_fire    = byte_valid_i & byte_ready_o;
	assign sr_in_o      = shreg[7];

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (reset_i)
		begin
			shreg     <= '0;
			last_q    <= 1'b0;
			loaded    <= 1'b0;
			bit_idx   <= '0;
			sr_ck_o   <= 1'b0;
			sc_done_o <= 1'b0;
		end
		else
		begin
			sc_done_o <= byte_end & last_q;
			if (byte_fire)
			begin
				shreg   <= byte_i.data;
				last_q  <= byte_i.last;
				loaded  <= 1'b1;
				bit_idx <= 3'd7;
				sr_ck_o <= 1'b0;   // Low phase with first bit
			end
			else if (byte_end)
			begin
				loaded  <= 1'b0;   // Nothing waiting, clock parks low
				shreg   <= '0;
				sr_ck_o <= 1'b0;
			end
			else if (loaded)
			begin
				sr_ck_o <= ~sr_ck_o;
				if (sr_ck_o)
				begin
					bit_idx <= bit_idx - 1'b1;  // Next bit after high phase
					shreg   <= shreg << 1;
				end
			end
		end
	end

endmodule

// File: hdl/acq_sequencer.sv
// Acquisition and readout sequencer
`timescale 1ns/1ns

module acq_sequencer
(
	input  logic                  Clk_Out_2_All,
	input  logic                  reset_i,
	input  logic                  acq_enable_i,
	input  logic                  chipsatb_i,     // Low when memory is full
	input  logic                  end_readout_i,
	output sk_daq_pkg::acq_ctrl_t acq_ctrl_o
);

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_ACQ,        // start_acq high
		ST_RO_START,   // Single cycle
		ST_WAIT_END
	} acq_state_t;

	acq_state_t state;

	// Moore outputs, one-hot per state
	assign acq_ctrl_o.start_acq     = (state == ST_ACQ);
	assign acq_ctrl_o.start_readout = (state == ST_RO_START);

	////////////////////////////////////////
	// FSM
	////////////////////////////////////////

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (reset_i)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE:
					if (acq_enable_i)
						state <= ST_ACQ;
				ST_ACQ:
					if (!acq_enable_i)
						state <= ST_IDLE;       // Stopped by host
					else if (!chipsatb_i)
						state <= ST_RO_START;   // Memory full
				ST_RO_START:
					state <= ST_WAIT_END;
				ST_WAIT_END:
					if (end_readout_i)
						state <= ST_IDLE;       // Re-arms from idle if still enabled
				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: hdl/dout_deserializer.sv
// Serial readout deserializer
`timescale 1ns/1ns
`include "sk_daq_settings.svh"

module dout_deserializer
(
	input  logic                  Clk_Out_2_All,
	input  logic                  reset_i,
	input  logic                  dout_b_i,         // Inverted data line
	input  logic                  transmit_on_b_i,  // Low while sending
	output logic [`SK_WORD_W-1:0] word_o,
	output logic                  word_valid_o
);

	localparam int CNT_W = $clog2(`SK_WORD_W);

	logic [`SK_WORD_W-1:0] shreg;
	logic [CNT_W-1:0]      bit_cnt;
	logic                  din;
	logic                  tx_active;
	logic                  word_done;  // 16th bit this cycle

	assign din       = ~dout_b_i;
	assign tx_active = ~transmit_on_b_i;
	assign word_done = tx_active & (bit_cnt == CNT_W'(`SK_WORD_W - 1));

	// MSB first, shift in from the bottom
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (tx_active)
			shreg <= {shreg[`SK_WORD_W-2:0], din};
		if (word_done)
			word_o <= {shreg[`SK_WORD_W-2:0], din};
	end

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (reset_i)
		begin
			bit_cnt      <= '0;
			word_valid_o <= 1'b0;
		end
		else
		begin
			word_valid_o <= word_done;
			bit_cnt      <= tx_active ? bit_cnt + 1'b1 : '0;  // Partial word dropped
		end
	end

endmodule

// File: hdl/event_fifo.sv
// Readout event FIFO
`timescale 1ns/1ns
`include "sk_daq_settings.svh"

module event_fifo
(
	input  logic                  Clk_Out_2_All,
	input  logic                  reset_i,
	input  logic [`SK_WORD_W-1:0] word_i,
	input  logic                  word_valid_i,  // No stall toward the chip
	input  logic                  tx_ready_i,
	output logic [`SK_WORD_W-1:0] tx_data_o,
	output logic                  tx_valid_o,
	output logic                  overflow_o      // Sticky
);

	localparam int PTR_W = $clog2(`SK_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`SK_FIFO_DEPTH + 1);

	logic [`SK_WORD_W-1:0] mem [`SK_FIFO_DEPTH];
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [CNT_W-1:0]      fill;
	logic                  full;
	logic                  push;
	logic                  pop;

	assign full       = (fill == CNT_W'(`SK_FIFO_DEPTH));
	assign push       = word_valid_i & ~full;   // Drop when full
	assign pop        = tx_valid_o & tx_ready_i;
	assign tx_valid_o = (fill != '0);
	assign tx_data_o  = mem[rd_ptr];             // Head word

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (push)
			mem[wr_ptr] <= word_i;
	end

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (reset_i)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill       <= '0;
			overflow_o <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				fill <= fill + 1'b1;
			else if (pop && !push)
				fill <= fill - 1'b1;
			if (word_valid_i && full)
				overflow_o <= 1'b1;
		end
	end

endmodule

// File: hdl/sk_daq_top.sv
// Readout chip front-end controller
`timescale 1ns/1ns
`include "sk_daq_settings.svh"

module sk_daq_top
(
	input  logic                  Clk_Out_2_All,
	input  logic                  reset_i,
	input  sk_daq_pkg::cmd_word_u cmd_data_i,
	input  logic                  cmd_valid_i,
	output logic                  cmd_ready_o,
	output logic                  sr_ck_o,
	output logic                  sr_in_o,
	output logic                  sc_done_o,
	input  logic                  chipsatb_i,      // Memory full, active low
	input  logic                  end_readout_i,
	output logic                  start_acq_o,
	output logic                  start_readout_o,
	input  logic                  dout_b_i,
	input  logic                  transmit_on_b_i,
	output logic [`SK_WORD_W-1:0] tx_data_o,
	output logic                  tx_valid_o,
	input  logic                  tx_ready_i,
	output logic                  overflow_o
);

	////////////////////////////////////////
	// Internal links
	////////////////////////////////////////

	sk_daq_pkg::sc_settings_t settings;
	logic                     sc_start;
	logic                     sc_busy;
	logic                     acq_enable;
	sk_daq_pkg::sc_byte_t     sc_byte;       // Builder to shifter
	logic                     sc_byte_valid;
	logic                     sc_byte_ready;
	sk_daq_pkg::acq_ctrl_t    acq_ctrl;
	logic [`SK_WORD_W-1:0]    ro_word;       // Deserializer to FIFO
	logic                     ro_word_valid;

	assign start_acq_o     = acq_ctrl.start_acq;
	assign start_readout_o = acq_ctrl.start_readout;

	cmd_decoder cmd_decoder_i
	(
		.Clk_Out_2_All (Clk_Out_2_All),
		.reset_i       (reset_i),
		.cmd_data_i    (cmd_data_i),
		.cmd_valid_i   (cmd_valid_i),
		.sc_busy_i     (sc_busy),
		.cmd_ready_o   (cmd_ready_o),
		.settings_o    (settings),
		.sc_start_o    (sc_start),
		.acq_enable_o  (acq_enable)
	);

	sc_frame_builder sc_frame_builder_i
	(
		.Clk_Out_2_All (Clk_Out_2_All),
		.reset_i       (reset_i),
		.settings_i    (settings),
		.sc_start_i    (sc_start),
		.sc_done_i     (sc_done_o),      // Shifter closes the frame
		.byte_ready_i  (sc_byte_ready),
		.sc_busy_o     (sc_busy),
		.byte_o        (sc_byte),
		.byte_valid_o  (sc_byte_valid)
	);

	sc_shifter sc_shifter_i
	(
		.Clk_Out_2_All (Clk_Out_2_All),
		.reset_i       (reset_i),
		.byte_i        (sc_byte),
		.byte_valid_i  (sc_byte_valid),
		.byte_ready_o  (sc_byte_ready),
		.sr_ck_o       (sr_ck_o),
		.sr_in_o       (sr_in_o),
		.sc_done_o     (sc_done_o)
	);

	acq_sequencer acq_sequencer_i
	(
		.Clk_Out_2_All (Clk_Out_2_All),
		.reset_i       (reset_i),
		.acq_enable_i  (acq_enable),
		.chipsatb_i    (chipsatb_i),
		.end_readout_i (end_readout_i),
		.acq_ctrl_o    (acq_ctrl)
	);

	dout_deserializer dout_deserializer_i
	(
		.Clk_Out_2_All   (Clk_Out_2_All),
		.reset_i         (reset_i),
		.dout_b_i        (dout_b_i),
		.transmit_on_b_i (transmit_on_b_i),
		.word_o          (ro_word),
		.word_valid_o    (ro_word_valid)
	);

	event_fifo event_fifo_i
	(
		.Clk_Out_2_All (Clk_Out_2_All),
		.reset_i       (reset_i),
		.word_i        (ro_word),
		.word_valid_i  (ro_word_valid),
		.tx_ready_i    (tx_ready_i),
		.tx_data_o     (tx_data_o),
		.tx_valid_o    (tx_valid_o),
		.overflow_o    (overflow_o)
	);

endmodule

// File: testbench/tb_sk_daq_top.sv
// Front-end controller testbench
`timescale 1ns/1ns
`include "sk_daq_settings.svh"

module tb_sk_daq_top;

	logic                  Clk_Out_2_All;
	logic                  reset_i;
	logic [`SK_CMD_W-1:0]  cmd_data;
	logic                  cmd_valid;
	logic                  cmd_ready;
	logic                  sr_ck;
	logic                  sr_in;
	logic                  sc_done;
	logic                  chipsatb;        // Active low
	logic                  end_readout;
	logic                  start_acq;
	logic                  start_readout;
	logic                  dout_b;
	logic                  transmit_on_b;
	logic [`SK_WORD_W-1:0] tx_data;
	logic                  tx_valid;
	logic                  tx_ready;
	logic                  overflow;

	// Register model
	logic [`SK_THR_W-1:0]    thr_m;
	logic [`SK_CHIPID_W-1:0] chip_m;
	logic [`SK_FBCAP_W-1:0]  fbcap_m;
	logic                    disc_m;
	logic                    ext_m;
	logic [`SK_MASK_W-1:0]   mask_m;

	logic [`SK_WORD_W-1:0] exp_q[$];   // Words the host should see in order
	byte                   rec_kind[$];
	logic [23:0]           rec_val[$];
	logic [23:0]           rec_exp[$];
	int                    cycles = 0;
	int                    cycle_limit = 0;   // Set once the records are known

	sk_daq_top sk_daq_top_i
	(
		.Clk_Out_2_All   (Clk_Out_2_All),
		.reset_i         (reset_i),
		.cmd_data_i      (cmd_data),
		.cmd_valid_i     (cmd_valid),
		.cmd_ready_o     (cmd_ready),
		.sr_ck_o         (sr_ck),
		.sr_in_o         (sr_in),
		.sc_done_o       (sc_done),
		.chipsatb_i      (chipsatb),
		.end_readout_i   (end_readout),
		.start_acq_o     (start_acq),
		.start_readout_o (start_readout),
		.dout_b_i        (dout_b),
		.transmit_on_b_i (transmit_on_b),
		.tx_data_o       (tx_data),
		.tx_valid_o      (tx_valid),
		.tx_ready_i      (tx_ready),
		.overflow_o      (overflow)
	);

	initial
	begin
		Clk_Out_2_All = 1'b0;
		forever #5 Clk_Out_2_All = ~Clk_Out_2_All;   // 100 MHz
	end

	always @(posedge Clk_Out_2_All)
	begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit)
			fail_run("Timeout: the DUT did not finish the stimulus in time");
	end

	////////////////////////////////////////
	// Reporting
	////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_value(input string name, input logic [71:0] got,
		input logic [71:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			fail_run("Stopping at the first mismatch");
		end
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Frame order from bit 71 down
	function automatic logic [71:0] model_frame();
		return {thr_m, chip_m, fbcap_m, disc_m, ext_m, mask_m};
	endfunction

	task automatic model_write(input logic [`SK_CMD_W-1:0] w);
		logic [`SK_ADDR_W-1:0] addr;
		logic [`SK_DATA_W-1:0] data;
		addr = w[14:12];
		data = w[11:0];
		case (addr)
			`SK_REG_THR:    thr_m = data[9:0];
			`SK_REG_CHIPID: chip_m = data[7:0];
			`SK_REG_OPT:
			begin
				fbcap_m = data[3:0];
				disc_m  = data[4];
				ext_m   = data[5];
			end
			`SK_REG_MASK0, `SK_REG_MASK1, `SK_REG_MASK2, `SK_REG_MASK3:
				mask_m[(addr - 3) * `SK_DATA_W +: `SK_DATA_W] = data;   // 12 channels per slice
			default: ;   // Unmapped address ignored
		endcase
	endtask

	////////////////////////////////////////
	// Drivers
	////////////////////////////////////////

	// Returns on the edge that takes the word
	task automatic send_cmd(input logic [`SK_CMD_W-1:0] w);
		@(posedge Clk_Out_2_All);
		cmd_data  <= w;
		cmd_valid <= 1'b1;
		do
			@(negedge Clk_Out_2_All);
		while (!cmd_ready);
		@(posedge Clk_Out_2_All);
		cmd_valid <= 1'b0;
	endtask

	task automatic run_config(input logic [23:0] hold);
		logic [71:0] frame_exp;
		logic [71:0] bits;
		int          nbits;
		int          dones;
		int          post;
		logic        prev_ck;
		logic        pending;   // Hold-off write still waiting
		frame_exp = model_frame();
		bits      = '0;
		nbits     = 0;
		dones     = 0;
		post      = 0;
		prev_ck   = 1'b0;
		pending   = hold[16];
		send_cmd({1'b1, `SK_ACT_CONFIG, 12'h000});
		if (pending)
		begin
			cmd_data  <= hold[15:0];   // Offered while the frame runs
			cmd_valid <= 1'b1;
		end
		while (post < 8)
		begin
			@(negedge Clk_Out_2_All);
			if (sr_ck && !prev_ck)
			begin
				bits = {bits[70:0], sr_in};   // Chip samples on rising sr_ck
				nbits++;
			end
			prev_ck = sr_ck;
			if (sc_done)
				dones++;
			if (cmd_valid && cmd_ready)
			begin
				if (dones == 0)
					fail_run("Write accepted during the configuration frame");
				@(posedge Clk_Out_2_All);
				cmd_valid <= 1'b0;
				model_write(hold[15:0]);   // Counts for the next frame only
				pending = 1'b0;
			end
			if (dones != 0 && !pending)
				post++;
		end
		check_value("sr_in_o bit count", nbits, 72);
		check_value("sr_in_o frame", bits, frame_exp);
		check_value("sc_done_o pulses", dones, 1);
	endtask

	task automatic run_acq(input int rounds, input int exp_pulses);
		int pulses;
		int r;
		pulses = 0;
		send_cmd({1'b1, `SK_ACT_ACQ_START, 12'h000});
		for (r = 0; r < rounds; r++)
		begin
			do
				@(negedge Clk_Out_2_All);
			while (!start_acq);
			@(posedge Clk_Out_2_All);
			chipsatb <= 1'b0;   // Memory full
			@(posedge Clk_Out_2_All);
			chipsatb <= 1'b1;
			repeat (6)
			begin
				@(negedge Clk_Out_2_All);
				if (start_readout)
					pulses++;
				check_value("start_acq_o", start_acq, 1'b0);
			end
			@(posedge Clk_Out_2_All);
			end_readout <= 1'b1;
			@(posedge Clk_Out_2_All);
			end_readout <= 1'b0;
		end
		do
			@(negedge Clk_Out_2_All);   // Re-armed while still enabled
		while (!start_acq);
		check_value("start_readout_o pulses", pulses, exp_pulses);
		send_cmd({1'b1, `SK_ACT_ACQ_STOP, 12'h000});
		repeat (2) @(posedge Clk_Out_2_All);
		repeat (8)
		begin
			@(negedge Clk_Out_2_All);
			check_value("start_acq_o", start_acq, 1'b0);
		end
	endtask

	// MSB first with the line carrying the inverse
	task automatic send_bits(input logic [`SK_WORD_W-1:0] w, input int count);
		int i;
		for (i = 0; i < count; i++)
		begin
			@(posedge Clk_Out_2_All);
			transmit_on_b <= 1'b0;
			dout_b        <= ~w[15 - (i % 16)];
		end
	endtask

	task automatic end_transmit();
		@(posedge Clk_Out_2_All);
		transmit_on_b <= 1'b1;
		dout_b        <= 1'b1;
	endtask

	task automatic drain_host();
		while (exp_q.size() != 0)
		begin
			@(posedge Clk_Out_2_All);
			tx_ready <= ($urandom % 4) != 0;   // Random ready gaps
			@(negedge Clk_Out_2_All);
			if (tx_valid && tx_ready)
				check_value("tx_data_o", tx_data, exp_q.pop_front());
		end
		@(posedge Clk_Out_2_All);
		tx_ready <= 1'b0;
		repeat (3) @(negedge Clk_Out_2_All);
		check_value("tx_valid_o", tx_valid, 1'b0);   // No stray or partial word
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		int          fd;
		int          idx;
		int          k;
		string       line;
		byte         kind;
		logic [23:0] val;
		logic [23:0] exp;
		void'($urandom(32'h9d317224));
		reset_i       = 1'b1;
		cmd_data      = '0;
		cmd_valid     = 1'b0;
		chipsatb      = 1'b1;
		end_readout   = 1'b0;
		dout_b        = 1'b1;   // Idle line
		transmit_on_b = 1'b1;
		tx_ready      = 1'b0;
		thr_m         = '0;
		chip_m        = '0;
		fbcap_m       = '0;
		disc_m        = 1'b0;
		ext_m         = 1'b0;
		mask_m        = '0;
		fd = $fopen("testbench/sk_daq_stim.txt", "r");
		if (fd == 0)
			fail_run("Cannot open the stimulus file testbench/sk_daq_stim.txt");
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 2 && line.getc(0) != "#"
				&& $sscanf(line, "%c %h %h", kind, val, exp) == 3)
			begin
				rec_kind.push_back(kind);
				rec_val.push_back(val);
				rec_exp.push_back(exp);
			end
		end
		$fclose(fd);
		cycle_limit = 400 * rec_kind.size();
		repeat (4) @(posedge Clk_Out_2_All);
		reset_i <= 1'b0;
		@(negedge Clk_Out_2_All);
		check_value("cmd_ready_o", cmd_ready, 1'b1);   // Idle after reset
		check_value("sr_ck_o", sr_ck, 1'b0);
		check_value("sr_in_o", sr_in, 1'b0);
		check_value("sc_done_o", sc_done, 1'b0);
		check_value("start_acq_o", start_acq, 1'b0);
		check_value("start_readout_o", start_readout, 1'b0);
		check_value("tx_valid_o", tx_valid, 1'b0);
		check_value("overflow_o", overflow, 1'b0);
		for (idx = 0; idx < rec_kind.size(); idx++)
		begin
			val = rec_val[idx];
			exp = rec_exp[idx];
			case (rec_kind[idx])
				"W":
					if (val[15] && val[14:12] == `SK_ACT_CONFIG)
						run_config(exp);
					else
					begin
						send_cmd(val[15:0]);
						if (!val[15])
							model_write(val[15:0]);
					end
				"A": run_acq(val, exp);
				"R":
				begin
					exp_q.push_back(val[15:0]);
					send_bits(val[15:0], 16 + val[19:16]);   // Trailing bits form no word
					end_transmit();
					drain_host();
					check_value("overflow_o", overflow, exp[0]);
				end
				"B":
				begin
					for (k = 0; k < val; k++)
					begin
						if (exp_q.size() < `SK_FIFO_DEPTH)
							exp_q.push_back(16'hb000 + k[15:0]);   // Beyond depth is lost
						send_bits(16'hb000 + k[15:0], 16);
					end
					end_transmit();
					repeat (3) @(posedge Clk_Out_2_All);
					@(negedge Clk_Out_2_All);
					check_value("overflow_o", overflow, exp[0]);
					drain_host();
				end
				default: fail_run("Unknown record letter in the stimulus file");
			endcase
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: sk_daq_top.f
+incdir+hdl
hdl/sk_daq_pkg.sv
hdl/cmd_decoder.sv
hdl/sc_frame_builder.sv
hdl/sc_shifter.sv
hdl/acq_sequencer.sv
hdl/dout_deserializer.sv
hdl/event_fifo.sv
hdl/sk_daq_top.sv
testbench/tb_sk_daq_top.sv

// File: testbench/sk_daq_stim.txt
# letter value expected: W cmd / hold-off write (bit 16 flags it), A rounds / readout pulses
# R word, trailing bits in 19:16 / overflow; B words sent with host ready low / overflow
W 0123 0
W 10a5 0
W 2035 0
W 3abc 0
W 4def 0
W 5123 0
W 6fed 0
W 7fff 0
W 8000 0
W 0055 0
W 2016 0
W 8000 10199
W 8000 0
A 3 3
R 0a5c3 0
R 31234 0
R 0ffff 0
R 50001 0
B 11 1
R 0beef 1
